// File: rob_vectors.txt
# T name | D tag rd pc type | C tag data taken | L tag ready data | K dispatch_ready retire_valid
# R tag rd data pc branch taken back_to_back | S stall_cycles | I idle_cycles ; fields in hex
T reset
K 1 0
L 0 0 00000000
T order
D 0 01 00001000 0
D 1 02 00001004 1
D 2 03 00001008 2
D 3 04 0000100c 3
C 3 dd000003 0
C 2 dd000002 0
C 1 dd000001 0
C 0 dd000000 0
R 0 01 dd000000 00001000 0 0 0
R 1 02 dd000001 00001004 0 0 1
R 2 03 dd000002 00001008 0 0 1
R 3 04 dd000003 0000100c 0 0 1
T lookup
D 4 05 00002000 0
D 5 06 00002004 3
L 5 0 00000000
C 5 12345678 0
L 5 1 12345678
C 4 cafe0004 0
R 4 05 cafe0004 00002000 0 0 0
R 5 06 12345678 00002004 0 0 1
L 5 0 00000000
T branch
D 6 07 00003000 4
D 7 08 00003004 1
C 6 bb000006 1
C 7 bb000007 0
R 6 07 bb000006 00003000 1 1 0
R 7 08 bb000007 00003004 0 0 1
T backpressure
D 8 10 00004000 0
D 9 11 00004004 0
D a 12 00004008 1
D b 13 0000400c 2
D c 14 00004010 3
D d 15 00004014 4
D e 16 00004018 0
D f 17 0000401c 1
D 0 18 00004020 2
D 1 19 00004024 3
D 2 1a 00004028 4
D 3 1b 0000402c 0
D 4 1c 00004030 1
D 5 1d 00004034 2
D 6 1e 00004038 3
D 7 1f 0000403c 0
K 0 0
C 8 a0000008 0
I 2
D 8 01 00004040 0
K 0 1
S 3
C 9 a0000009 0
R 8 10 a0000008 00004000 0 0 0
K 1 1
D 9 02 00004044 0
K 0 1
R 9 11 a0000009 00004004 0 0 1

// File: list.f
rob_pkg.sv
rob_tag_fifo.sv
rob_entry_file.sv
rob_retire.sv
rob.sv
tb_rob.sv

// File: Makefile
# Verilator build and run of the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_rob
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VECTORS   ?= rob_vectors.txt
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= sim passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass message in the simulator output
run: $(BIN) $(VECTORS)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: tb_rob.sv
/*
  vector driven testbench, reads rob_vectors.txt from the project root
  vector tags must follow dispatch order modulo ROB_DEPTH
*/
`timescale 1ns/1ps
`default_nettype none

module tb_rob;

    localparam int TIMEOUT = 200;

    logic                          i_clk;
    logic                          i_reset;
    logic                          i_dispatch_valid;
    logic                          o_dispatch_ready;
    logic [rob_pkg::ROB_TAG_W-1:0] i_dispatch_tag;
    logic [rob_pkg::REG_W-1:0]     i_dispatch_rd;
    logic [rob_pkg::XLEN-1:0]      i_dispatch_pc;
    rob_pkg::instr_type_e          i_dispatch_type;
    logic                          i_cdb_valid;
    logic [rob_pkg::ROB_TAG_W-1:0] i_cdb_tag;
    logic [rob_pkg::XLEN-1:0]      i_cdb_data;
    logic                          i_cdb_branch_taken;
    logic [rob_pkg::ROB_TAG_W-1:0] i_rs1_tag;
    logic                          o_rs1_ready;
    logic [rob_pkg::XLEN-1:0]      o_rs1_data;
    logic [rob_pkg::ROB_TAG_W-1:0] i_rs2_tag;
    logic                          o_rs2_ready;
    logic [rob_pkg::XLEN-1:0]      o_rs2_data;
    logic                          o_retire_valid;
    logic                          i_retire_ready;
    logic [rob_pkg::ROB_TAG_W-1:0] o_retire_tag;
    logic [rob_pkg::REG_W-1:0]     o_retire_rd;
    logic [rob_pkg::XLEN-1:0]      o_retire_data;
    logic [rob_pkg::XLEN-1:0]      o_retire_pc;
    logic                          o_retire_branch;
    logic                          o_retire_taken;

    // vector reader state
    int              fd;
    int              code;
    logic [7:0]      cmd;
    logic [8*128-1:0] line;
    logic [8*24-1:0] test_name;
    logic            test_open;
    logic [31:0]     f0;
    logic [31:0]     f1;
    logic [31:0]     f2;
    logic [31:0]     f3;
    logic [31:0]     f4;
    logic [31:0]     f5;
    logic [31:0]     f6;

    // bookkeeping
    int   checks;
    int   errors;
    int   test_errors;
    int   tests_run;
    int   tests_failed;
    logic timed_out;

    rob dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // inputs move 1 ns after the edge, outputs are sampled there too
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic report_error(input string what);
        errors = errors + 1;
        test_errors = test_errors + 1;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks = checks + 1;
        if (exp !== act) begin
            errors = errors + 1;
            test_errors = test_errors + 1;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        compare_field(name, 32'(exp), 32'(act));
    endtask

    task automatic check_operand(input string port, input logic exp_ready,
                                 input logic [rob_pkg::XLEN-1:0] exp_data,
                                 input logic act_ready,
                                 input logic [rob_pkg::XLEN-1:0] act_data);
        compare_field($sformatf("%s_ready", port), 32'(exp_ready), 32'(act_ready));
        compare_field($sformatf("%s_data", port), exp_data, act_data);
    endtask

    task automatic check_retire(input logic [rob_pkg::ROB_TAG_W-1:0] tag,
                                input logic [rob_pkg::REG_W-1:0] rd,
                                input logic [rob_pkg::XLEN-1:0] data,
                                input logic [rob_pkg::XLEN-1:0] pc,
                                input logic branch, input logic taken);
        compare_field("o_retire_tag", 32'(tag), 32'(o_retire_tag));
        compare_field("o_retire_rd", 32'(rd), 32'(o_retire_rd));
        compare_field("o_retire_data", data, o_retire_data);
        compare_field("o_retire_pc", pc, o_retire_pc);
        check_bit("o_retire_branch", branch, o_retire_branch);
        check_bit("o_retire_taken", taken, o_retire_taken);
    endtask

    task automatic print_summary();
        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
    endtask

    // a timeout stops the vector loop, the run then ends as a failure
    task automatic report_timeout(input string what);
        errors = errors + 1;
        test_errors = test_errors + 1;
        timed_out = 1'b1;
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    endtask

    task automatic wait_dispatch_ready();
        int n;
        n = 0;
        while (!o_dispatch_ready && n < TIMEOUT) begin
            next_cycle();
            n = n + 1;
        end
        if (!o_dispatch_ready) report_timeout("dispatch ready");
    endtask

    task automatic wait_retire_valid();
        int n;
        n = 0;
        while (!o_retire_valid && n < TIMEOUT) begin
            next_cycle();
            n = n + 1;
        end
        if (!o_retire_valid) report_timeout("retire valid");
    endtask

    // stall the retire port and expect a frozen output
    task automatic hold_retire(input int cycles);
        logic [rob_pkg::ROB_TAG_W-1:0] tag;
        logic [rob_pkg::REG_W-1:0]     rd;
        logic [rob_pkg::XLEN-1:0]      data;
        logic [rob_pkg::XLEN-1:0]      pc;
        logic                          branch;
        logic                          taken;
        if (!o_retire_valid) begin
            report_error("stall asked for while no retire is pending");
        end else begin
            tag = o_retire_tag;
            rd = o_retire_rd;
            data = o_retire_data;
            pc = o_retire_pc;
            branch = o_retire_branch;
            taken = o_retire_taken;
            i_retire_ready = 1'b0;
            repeat (cycles) begin
                next_cycle();
                check_bit("o_retire_valid", 1'b1, o_retire_valid);
                check_retire(tag, rd, data, pc, branch, taken);
            end
        end
    endtask

    task automatic close_test();
        if (test_open) begin
            tests_run = tests_run + 1;
            if (test_errors == 0) begin
                $display("test %0s: ok", test_name);
            end else begin
                tests_failed = tests_failed + 1;
                $display("test %0s: %0d errors", test_name, test_errors);
            end
        end
        test_errors = 0;
    endtask

    task automatic check_field_count(input int got, input int want);
        if (got != want) report_error("malformed line in the vector file");
    endtask

    task automatic run_command();
        if (cmd == "#") begin
            code = $fgets(line, fd);
        end else if (cmd == "T") begin
            close_test();
            code = $fscanf(fd, "%s", test_name);
            test_open = 1'b1;
        end else if (cmd == "D") begin
            code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
            check_field_count(code, 4);
            wait_dispatch_ready();
            if (!timed_out) begin
                i_dispatch_valid = 1'b1;
                i_dispatch_tag = f0[rob_pkg::ROB_TAG_W-1:0];
                i_dispatch_rd = f1[rob_pkg::REG_W-1:0];
                i_dispatch_pc = f2;
                i_dispatch_type = rob_pkg::instr_type_e'(f3[2:0]);
                next_cycle();
                i_dispatch_valid = 1'b0;
            end
        end else if (cmd == "C") begin
            code = $fscanf(fd, "%h %h %h", f0, f1, f2);
            check_field_count(code, 3);
            i_cdb_valid = 1'b1;
            i_cdb_tag = f0[rob_pkg::ROB_TAG_W-1:0];
            i_cdb_data = f1;
            i_cdb_branch_taken = f2[0];
            next_cycle();
            i_cdb_valid = 1'b0;
        end else if (cmd == "L") begin
            code = $fscanf(fd, "%h %h %h", f0, f1, f2);
            check_field_count(code, 3);
            // both lookup ports see the same tag
            i_rs1_tag = f0[rob_pkg::ROB_TAG_W-1:0];
            i_rs2_tag = f0[rob_pkg::ROB_TAG_W-1:0];
            next_cycle();
            check_operand("o_rs1", f1[0], f2, o_rs1_ready, o_rs1_data);
            check_operand("o_rs2", f1[0], f2, o_rs2_ready, o_rs2_data);
        end else if (cmd == "R") begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
            check_field_count(code, 7);
            // back to back means valid is already up with no gap
            if (f6[0]) check_bit("o_retire_valid", 1'b1, o_retire_valid);
            wait_retire_valid();
            if (!timed_out) begin
                check_retire(f0[rob_pkg::ROB_TAG_W-1:0], f1[rob_pkg::REG_W-1:0],
                             f2, f3, f4[0], f5[0]);
                i_retire_ready = 1'b1;
                next_cycle();
                i_retire_ready = 1'b0;
            end
        end else if (cmd == "S") begin
            code = $fscanf(fd, "%h", f0);
            hold_retire(int'(f0));
        end else if (cmd == "I") begin
            code = $fscanf(fd, "%h", f0);
            repeat (int'(f0)) next_cycle();
        end else if (cmd == "K") begin
            code = $fscanf(fd, "%h %h", f0, f1);
            check_field_count(code, 2);
            check_bit("o_dispatch_ready", f0[0], o_dispatch_ready);
            check_bit("o_retire_valid", f1[0], o_retire_valid);
        end else begin
            report_error("unknown command in the vector file");
        end
    endtask

    initial begin
        i_reset = 1'b1;
        i_dispatch_valid = 1'b0;
        i_dispatch_tag = '0;
        i_dispatch_rd = '0;
        i_dispatch_pc = '0;
        i_dispatch_type = rob_pkg::INSTR_INT;
        i_cdb_valid = 1'b0;
        i_cdb_tag = '0;
        i_cdb_data = '0;
        i_cdb_branch_taken = 1'b0;
        i_rs1_tag = '0;
        i_rs2_tag = '0;
        i_retire_ready = 1'b0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        test_open = 1'b0;
        test_name = '0;
        fd = $fopen("rob_vectors.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open rob_vectors.txt");
            $display("sim failed");
            $finish;
        end else begin
            // reset held over 4 rising edges
            repeat (4) @(posedge i_clk);
            #1;
            i_reset = 1'b0;
            code = $fscanf(fd, "%s", cmd);
            while (code == 1 && !timed_out) begin
                run_command();
                code = $fscanf(fd, "%s", cmd);
            end
            close_test();
            $fclose(fd);
            print_summary();
            if (errors == 0 && !timed_out) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rob.sv
/*
  reorder buffer top, dispatch picks tags in sequence modulo ROB_DEPTH
  no flush, store or exception handling
*/
`timescale 1ns/1ps
`default_nettype none

module rob (
    input  wire logic                          i_clk,
    input  wire logic                          i_reset,
    // dispatch
    input  wire logic                          i_dispatch_valid,
    output logic                               o_dispatch_ready,
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_dispatch_tag,
    input  wire logic [rob_pkg::REG_W-1:0]     i_dispatch_rd,
    input  wire logic [rob_pkg::XLEN-1:0]      i_dispatch_pc,
    input  rob_pkg::instr_type_e               i_dispatch_type,
    // cdb broadcast
    input  wire logic                          i_cdb_valid,
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_cdb_tag,
    input  wire logic [rob_pkg::XLEN-1:0]      i_cdb_data,
    input  wire logic                          i_cdb_branch_taken,
    // operand lookups
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_rs1_tag,
    output logic                               o_rs1_ready,
    output logic      [rob_pkg::XLEN-1:0]      o_rs1_data,
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_rs2_tag,
    output logic                               o_rs2_ready,
    output logic      [rob_pkg::XLEN-1:0]      o_rs2_data,
    // retire
    output logic                               o_retire_valid,
    input  wire logic                          i_retire_ready,
    output logic      [rob_pkg::ROB_TAG_W-1:0] o_retire_tag,
    output logic      [rob_pkg::REG_W-1:0]     o_retire_rd,
    output logic      [rob_pkg::XLEN-1:0]      o_retire_data,
    output logic      [rob_pkg::XLEN-1:0]      o_retire_pc,
    output logic                               o_retire_branch,
    output logic                               o_retire_taken
);

    logic                          fifo_full;
    logic                          fifo_empty;
    logic [rob_pkg::ROB_TAG_W-1:0] fifo_head_tag;
    logic                          dispatch_fire;
    logic                          pop;
    logic [rob_pkg::ROB_TAG_W-1:0] head_addr;

    // head entry fields back to retire
    logic                          head_done;
    logic [rob_pkg::REG_W-1:0]     head_rd;
    logic [rob_pkg::XLEN-1:0]      head_data;
    logic [rob_pkg::XLEN-1:0]      head_pc;
    rob_pkg::instr_type_e          head_type;
    logic                          head_taken;

    assign o_dispatch_ready = !fifo_full;

    // handshake drives both the fifo push and the entry write
    assign dispatch_fire = i_dispatch_valid && o_dispatch_ready;

    rob_tag_fifo u_tag_fifo (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_push     (dispatch_fire),
        .i_push_tag (i_dispatch_tag),
        .i_pop      (pop),
        .o_head_tag (fifo_head_tag),
        .o_full     (fifo_full),
        .o_empty    (fifo_empty)
    );

    rob_entry_file u_entry_file (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_wr_en            (dispatch_fire),
        .i_wr_tag           (i_dispatch_tag),
        .i_wr_rd            (i_dispatch_rd),
        .i_wr_pc            (i_dispatch_pc),
        .i_wr_type          (i_dispatch_type),
        .i_cdb_valid        (i_cdb_valid),
        .i_cdb_tag          (i_cdb_tag),
        .i_cdb_data         (i_cdb_data),
        .i_cdb_branch_taken (i_cdb_branch_taken),
        .i_rs1_tag          (i_rs1_tag),
        .o_rs1_ready        (o_rs1_ready),
        .o_rs1_data         (o_rs1_data),
        .i_rs2_tag          (i_rs2_tag),
        .o_rs2_ready        (o_rs2_ready),
        .o_rs2_data         (o_rs2_data),
        .i_head_tag         (head_addr),
        .i_clear            (pop),
        .o_head_done        (head_done),
        .o_head_rd          (head_rd),
        .o_head_data        (head_data),
        .o_head_pc          (head_pc),
        .o_head_type        (head_type),
        .o_head_taken       (head_taken)
    );

    // single pop frees the fifo slot and the head entry together
    rob_retire u_retire (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_empty         (fifo_empty),
        .i_head_tag      (fifo_head_tag),
        .i_head_done     (head_done),
        .i_head_rd       (head_rd),
        .i_head_data     (head_data),
        .i_head_pc       (head_pc),
        .i_head_type     (head_type),
        .i_head_taken    (head_taken),
        .i_retire_ready  (i_retire_ready),
        .o_head_addr     (head_addr),
        .o_pop           (pop),
        .o_retire_valid  (o_retire_valid),
        .o_retire_tag    (o_retire_tag),
        .o_retire_rd     (o_retire_rd),
        .o_retire_data   (o_retire_data),
        .o_retire_pc     (o_retire_pc),
        .o_retire_branch (o_retire_branch),
        .o_retire_taken  (o_retire_taken)
    );

endmodule

`default_nettype wire

// File: rob_retire.sv
/*
  registered retire stage, one entry per cycle at most
  outputs hold while o_retire_valid is high and i_retire_ready is low
*/
`timescale 1ns/1ps
`default_nettype none

module rob_retire (
    input  wire logic                          i_clk,
    input  wire logic                          i_reset,
    // fifo head
    input  wire logic                          i_empty,
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_head_tag,
    // head entry read back
    input  wire logic                          i_head_done,
    input  wire logic [rob_pkg::REG_W-1:0]     i_head_rd,
    input  wire logic [rob_pkg::XLEN-1:0]      i_head_data,
    input  wire logic [rob_pkg::XLEN-1:0]      i_head_pc,
    input  rob_pkg::instr_type_e               i_head_type,
    input  wire logic                          i_head_taken,
    input  wire logic                          i_retire_ready,
    output logic      [rob_pkg::ROB_TAG_W-1:0] o_head_addr,
    output logic                               o_pop,
    // retire port
    output logic                               o_retire_valid,
    output logic      [rob_pkg::ROB_TAG_W-1:0] o_retire_tag,
    output logic      [rob_pkg::REG_W-1:0]     o_retire_rd,
    output logic      [rob_pkg::XLEN-1:0]      o_retire_data,
    output logic      [rob_pkg::XLEN-1:0]      o_retire_pc,
    output logic                               o_retire_branch,
    output logic                               o_retire_taken
);

    rob_pkg::retire_state_e state;

    logic handoff;

    // head entry lives at the fifo head tag
    assign o_head_addr = i_head_tag;

    // current output taken by the consumer this cycle
    assign handoff = (state == rob_pkg::RET_HOLD) && i_retire_ready;

    // pop when head is done and the register is free or freeing up
    assign o_pop = !i_empty && i_head_done &&
                   ((state == rob_pkg::RET_IDLE) || handoff);

    assign o_retire_valid = (state == rob_pkg::RET_HOLD);

    // a pop refills the register and a bare handshake empties it
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= rob_pkg::RET_IDLE;
        end else if (o_pop) begin
            state <= rob_pkg::RET_HOLD;
        end else if (handoff) begin
            state <= rob_pkg::RET_IDLE;
        end
    end

    // output payload moves only on a pop
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            o_retire_tag    <= i_head_tag;
            o_retire_rd     <= i_head_rd;
            o_retire_data   <= i_head_data;
            o_retire_pc     <= i_head_pc;
            o_retire_branch <= (i_head_type == rob_pkg::INSTR_BRANCH);
            o_retire_taken  <= i_head_taken;
        end
    end

endmodule

`default_nettype wire

// File: rob_entry_file.sv
/*
  tag indexed entry storage, one entry per live tag
  CDB writes to an invalid tag are dropped; lookups of a not ready entry read zero
*/
`timescale 1ns/1ps
`default_nettype none

module rob_entry_file (
    input  wire logic                          i_clk,
    input  wire logic                          i_reset,
    // dispatch write
    input  wire logic                          i_wr_en,
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_wr_tag,
    input  wire logic [rob_pkg::REG_W-1:0]     i_wr_rd,
    input  wire logic [rob_pkg::XLEN-1:0]      i_wr_pc,
    input  rob_pkg::instr_type_e               i_wr_type,
    // cdb update
    input  wire logic                          i_cdb_valid,
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_cdb_tag,
    input  wire logic [rob_pkg::XLEN-1:0]      i_cdb_data,
    input  wire logic                          i_cdb_branch_taken,
    // operand lookups
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_rs1_tag,
    output logic                               o_rs1_ready,
    output logic      [rob_pkg::XLEN-1:0]      o_rs1_data,
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_rs2_tag,
    output logic                               o_rs2_ready,
    output logic      [rob_pkg::XLEN-1:0]      o_rs2_data,
    // head read and retire clear
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_head_tag,
    input  wire logic                          i_clear,
    output logic                               o_head_done,
    output logic      [rob_pkg::REG_W-1:0]     o_head_rd,
    output logic      [rob_pkg::XLEN-1:0]      o_head_data,
    output logic      [rob_pkg::XLEN-1:0]      o_head_pc,
    output rob_pkg::instr_type_e               o_head_type,
    output logic                               o_head_taken
);

    // control bits
    logic [rob_pkg::ROB_DEPTH-1:0] entry_valid;
    logic [rob_pkg::ROB_DEPTH-1:0] entry_done;

    // payload arrays
    logic [rob_pkg::REG_W-1:0] entry_rd    [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::XLEN-1:0]  entry_pc    [rob_pkg::ROB_DEPTH];
    rob_pkg::instr_type_e      entry_type  [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::XLEN-1:0]  entry_data  [rob_pkg::ROB_DEPTH];
    logic                      entry_taken [rob_pkg::ROB_DEPTH];

    // cdb only counts for a live entry
    logic cdb_hit;

    assign cdb_hit = i_cdb_valid && entry_valid[i_cdb_tag];

    // valid / done bookkeeping
    // clear first, dispatch last so a fresh entry always wins
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            entry_valid <= '0;
            entry_done  <= '0;
        end else begin
            if (i_clear) begin
                entry_valid[i_head_tag] <= 1'b0;
            end
            if (cdb_hit) begin
                entry_done[i_cdb_tag] <= 1'b1;
            end
            if (i_wr_en) begin
                entry_valid[i_wr_tag] <= 1'b1;
                entry_done[i_wr_tag]  <= 1'b0;
            end
        end
    end

    // dispatch fields
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            entry_rd[i_wr_tag]   <= i_wr_rd;
            entry_pc[i_wr_tag]   <= i_wr_pc;
            entry_type[i_wr_tag] <= i_wr_type;
        end
    end

    // speculative result from the cdb
    always_ff @(posedge i_clk) begin
        if (cdb_hit) begin
            entry_data[i_cdb_tag]  <= i_cdb_data;
            entry_taken[i_cdb_tag] <= i_cdb_branch_taken;
        end
    end

    // lookup ready means live and written back
    assign o_rs1_ready = entry_valid[i_rs1_tag] && entry_done[i_rs1_tag];
    assign o_rs2_ready = entry_valid[i_rs2_tag] && entry_done[i_rs2_tag];

    // zero when not ready so dispatch falls back to the arch file
    assign o_rs1_data = o_rs1_ready ? entry_data[i_rs1_tag] : '0;
    assign o_rs2_data = o_rs2_ready ? entry_data[i_rs2_tag] : '0;

    // head read for retire
    // done already folds in valid
    assign o_head_done  = entry_valid[i_head_tag] && entry_done[i_head_tag];
    assign o_head_rd    = entry_rd[i_head_tag];
    assign o_head_data  = entry_data[i_head_tag];
    assign o_head_pc    = entry_pc[i_head_tag];
    assign o_head_type  = entry_type[i_head_tag];
    assign o_head_taken = entry_taken[i_head_tag];

endmodule

`default_nettype wire

// File: rob_tag_fifo.sv
/*
  program order queue of dispatched tags
  caller must not pop when empty; push when full only with a pop in the same cycle
*/
`timescale 1ns/1ps
`default_nettype none

module rob_tag_fifo (
    input  wire logic                          i_clk,
    input  wire logic                          i_reset,
    input  wire logic                          i_push,
    input  wire logic [rob_pkg::ROB_TAG_W-1:0] i_push_tag,
    input  wire logic                          i_pop,
    output logic      [rob_pkg::ROB_TAG_W-1:0] o_head_tag,
    output logic                               o_full,
    output logic                               o_empty
);

    // tag storage
    logic [rob_pkg::ROB_TAG_W-1:0] tag_mem [rob_pkg::ROB_DEPTH];

    // msb of each pointer is the wrap bit
    logic [rob_pkg::ROB_PTR_W-1:0] wr_ptr;
    logic [rob_pkg::ROB_PTR_W-1:0] rd_ptr;

    logic [rob_pkg::ROB_TAG_W-1:0] wr_idx;
    logic [rob_pkg::ROB_TAG_W-1:0] rd_idx;

    logic push_ok;
    logic pop_ok;

    assign wr_idx = wr_ptr[rob_pkg::ROB_TAG_W-1:0];
    assign rd_idx = rd_ptr[rob_pkg::ROB_TAG_W-1:0];

    // same index, wrap bits differ -> full
    assign o_full = (wr_idx == rd_idx) &&
                    (wr_ptr[rob_pkg::ROB_PTR_W-1] != rd_ptr[rob_pkg::ROB_PTR_W-1]);

    // pointers fully equal -> empty
    assign o_empty = (wr_ptr == rd_ptr);

    // full slot frees up when popped this cycle
    assign push_ok = i_push && (!o_full || i_pop);
    assign pop_ok  = i_pop && !o_empty;

    // oldest tag sits at the read pointer
    assign o_head_tag = tag_mem[rd_idx];

    // pointer update
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage write
    always_ff @(posedge i_clk) begin
        if (push_ok) begin
            tag_mem[wr_idx] <= i_push_tag;
        end
    end

endmodule

`default_nettype wire

// File: rob_pkg.sv
/*
  sizes and enums shared by the reorder buffer blocks
  tag width must cover ROB_DEPTH exactly, the depth is a power of two
*/
`default_nettype none

package rob_pkg;

    // number of entries in flight
    localparam int ROB_DEPTH = 16;

    // tag indexes one entry
    localparam int ROB_TAG_W = 4;

    // fifo pointers carry one extra wrap bit
    localparam int ROB_PTR_W = ROB_TAG_W + 1;

    // architectural register index
    localparam int REG_W = 5;

    // data and pc width
    localparam int XLEN = 32;

    // instruction class written at dispatch
    // only INSTR_BRANCH raises the retire branch flag
    typedef enum logic [2:0] {
        INSTR_INT    = 3'd0,
        INSTR_MULT   = 3'd1,
        INSTR_DIV    = 3'd2,
        INSTR_LOAD   = 3'd3,
        INSTR_BRANCH = 3'd4
    } instr_type_e;

    // retire output register
    // idle means nothing presented on the port
    typedef enum logic {
        RET_IDLE = 1'b0,
        RET_HOLD = 1'b1
    } retire_state_e;

endpackage

`default_nettype wire
